// ==== verilog/eq_defines.svh ====
`ifndef EQ_DEFINES_SVH
`define EQ_DEFINES_SVH

// Sample window and symmetric FIR shape
`define EQ_TAPS 45
`define EQ_PAIRS 22

// Graphic EQ bands
`define EQ_BANDS 7

// Audio sample width, also used for accumulators and results
`define EQ_SAMPLE_W 32

// Coefficient magnitude, sign kept separately
`define EQ_COEF_W 14

// Per-band gain
`define EQ_GAIN_W 4

// Fixed scale applied to each band's accumulated value
`define EQ_SCALE_DIV 800000

`endif

// ==== verilog/eq_pkg.sv ====
`include "eq_defines.svh"

package eq_pkg;

  typedef struct packed {
    logic [`EQ_SAMPLE_W-1:0] left;
    logic [`EQ_SAMPLE_W-1:0] right;
  } stereo_t;

  // Signed-magnitude coefficient
  typedef struct packed {
    logic                  neg;
    logic [`EQ_COEF_W-1:0] mag;
  } coef_t;

  typedef coef_t [`EQ_PAIRS-1:0] band_coefs_t;

  typedef logic [`EQ_BANDS-1:0][`EQ_GAIN_W-1:0] band_gains_t;

  typedef logic [2:0] band_idx_t;

  //////////////////////////////////////////////////////////////////////
  // Coefficient tables, one row per band, pair 0 first
  //////////////////////////////////////////////////////////////////////

  localparam logic [`EQ_COEF_W-1:0] coef_mag [`EQ_BANDS][`EQ_PAIRS] = '{
    '{0, 0, 1, 2, 3, 5, 9, 13, 19, 27, 36,
      47, 59, 73, 87, 100, 120, 130, 140, 150, 160, 170},
    '{0, 1, 2, 4, 8, 15, 24, 36, 52, 73, 98,
      130, 160, 200, 240, 280, 320, 360, 390, 420, 440, 450},
    '{0, 2, 4, 10, 19, 35, 58, 92, 140, 200, 270,
      360, 470, 590, 710, 850, 980, 1110, 1230, 1320, 1400, 1440},
    '{1, 4, 14, 32, 65, 110, 180, 260, 340, 400, 410,
      330, 120, 230, 760, 1460, 2290, 3200, 4130, 4970, 5650, 6100},
    '{1, 4, 10, 14, 10, 2, 0, 55, 200, 420, 580,
      440, 270, 1680, 3600, 5440, 6320, 5450, 2490, 2110, 7130, 11030},
    '{1, 2, 3, 17, 24, 8, 0, 65, 160, 29, 580,
      1350, 1270, 590, 3600, 5160, 2620, 3650, 9280, 8970, 1530, 8110},
    '{0, 2, 0, 19, 34, 37, 180, 120, 360, 730, 0,
      1500, 1550, 1090, 3600, 1690, 3700, 5590, 0, 6870, 5600, 3150}
  };

  // Leftmost bit is pair 0
  localparam logic [0:`EQ_PAIRS-1] coef_neg [`EQ_BANDS] = '{
    22'b0000_0000_0000_0000_0000_00,
    22'b0000_0000_0000_0000_0000_00,
    22'b0000_0000_0000_0000_0000_00,
    22'b1111_1111_1111_1000_0000_00,
    22'b0000_0110_0000_1111_1110_00,
    22'b1100_0000_0011_1000_0111_10,
    22'b0001_1000_1100_0111_0001_10
  };

  function automatic band_coefs_t band_entry(input int b);
    band_coefs_t entry;
    for (int k = 0; k < `EQ_PAIRS; k++)
    begin
      entry[k].neg = coef_neg[b][k];
      entry[k].mag = coef_mag[b][k];
    end
    return entry;
  endfunction

  localparam band_coefs_t coef_table [`EQ_BANDS] = '{
    band_entry(0),
    band_entry(1),
    band_entry(2),
    band_entry(3),
    band_entry(4),
    band_entry(5),
    band_entry(6)
  };

endpackage

// ==== verilog/sample_window.sv ====
`include "eq_defines.svh"

module sample_window
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sample_strobe,
  input  eq_pkg::stereo_t         sample_in,
  output logic [`EQ_SAMPLE_W-1:0] left_taps  [`EQ_TAPS],
  output logic [`EQ_SAMPLE_W-1:0] right_taps [`EQ_TAPS]
);

  // Tap 0 holds the newest sample
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `EQ_TAPS; i++)
      begin
        left_taps[i]  <= '0;
        right_taps[i] <= '0;
      end
    end
    else if (sample_strobe)
    begin
      left_taps[0]  <= sample_in.left;
      right_taps[0] <= sample_in.right;
      for (int i = 1; i < `EQ_TAPS; i++)
      begin
        left_taps[i]  <= left_taps[i-1];
        right_taps[i] <= right_taps[i-1];
      end
    end
  end

endmodule

// ==== verilog/fir_pair_mac.sv ====
`include "eq_defines.svh"

module fir_pair_mac
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`EQ_SAMPLE_W-1:0] taps [`EQ_TAPS],
  input  eq_pkg::band_coefs_t     coefs,
  input  logic                    mac_start,
  output logic [`EQ_SAMPLE_W-1:0] acc,
  output logic                    acc_valid
);

  localparam int MSB = `EQ_SAMPLE_W - 1;

  logic [`EQ_SAMPLE_W-1:0] terms [`EQ_PAIRS];
  logic [`EQ_SAMPLE_W-1:0] term_sum;

  ////////////////////////////////////////////////////////////////////////
  // Mirrored pairs, centre tap 22 left out
  ////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < `EQ_PAIRS; k++)
  begin : g_pair
    logic [`EQ_SAMPLE_W-1:0] pair_sum;
    logic [`EQ_SAMPLE_W-1:0] pair_mag;
    logic [`EQ_SAMPLE_W-1:0] prod;

    assign pair_sum = taps[k] + taps[`EQ_TAPS-1-k];
    assign pair_mag = pair_sum[MSB] ? -pair_sum : pair_sum;
    assign prod     = {{(`EQ_SAMPLE_W-`EQ_COEF_W){1'b0}}, coefs[k].mag} * pair_mag;

    // Negative when coefficient and pair signs differ
    assign terms[k] = (coefs[k].neg ^ pair_sum[MSB]) ? -prod : prod;
  end

  always_comb
  begin
    term_sum = '0;
    for (int k = 0; k < `EQ_PAIRS; k++)
      term_sum = term_sum + terms[k];
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      acc_valid <= 1'b0;
    else
      acc_valid <= mac_start;
  end

  always_ff @(posedge clk)
  begin
    if (mac_start)
      acc <= term_sum;  // Wraps at 32 bits
  end

endmodule

// ==== verilog/band_scaler.sv ====
`include "eq_defines.svh"

module band_scaler
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`EQ_SAMPLE_W-1:0] acc,
  input  logic                    acc_valid,
  input  logic [`EQ_GAIN_W-1:0]   gain,
  output logic [`EQ_SAMPLE_W-1:0] result,
  output logic                    done
);

  localparam int MSB    = `EQ_SAMPLE_W - 1;
  localparam int STEP_W = $clog2(`EQ_SAMPLE_W);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`EQ_SAMPLE_W - 1);

  logic                    acc_neg;
  logic [`EQ_SAMPLE_W-1:0] quot;  // Dividend out at the top, quotient in at the bottom
  logic [`EQ_SAMPLE_W-1:0] rem;
  logic [`EQ_SAMPLE_W:0]   rem_shift;
  logic [`EQ_SAMPLE_W:0]   rem_sub;
  logic                    rem_fit;
  logic [STEP_W-1:0]       step;
  logic                    running;
  logic                    finish;
  logic [`EQ_SAMPLE_W-1:0] scaled;

  assign rem_shift = {rem, quot[MSB]};
  assign rem_sub   = rem_shift - `EQ_SCALE_DIV;
  assign rem_fit   = rem_shift >= `EQ_SCALE_DIV;
  assign scaled    = quot * `EQ_SAMPLE_W'(gain);

  ////////////////////////////////////////////////////////////////////////
  // Capture, 32 restoring steps, then gain and sign
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      running <= 1'b0;
      finish  <= 1'b0;
      done    <= 1'b0;
      step    <= '0;
    end
    else
    begin
      done   <= finish;
      finish <= running && (step == LAST_STEP);
      if (acc_valid)
      begin
        running <= 1'b1;
        step    <= '0;
      end
      else if (running)
      begin
        step <= step + 1'b1;
        if (step == LAST_STEP)
          running <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (acc_valid)
    begin
      acc_neg <= acc[MSB];
      quot    <= acc[MSB] ? -acc : acc;  // Magnitude
      rem     <= '0;
    end
    else if (running)
    begin
      quot <= {quot[MSB-1:0], rem_fit};
      rem  <= rem_fit ? rem_sub[MSB:0] : rem_shift[MSB:0];
    end

    if (finish)
      result <= acc_neg ? -scaled : scaled;
  end

  // Next band must wait for this result
  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    acc_valid |-> !(running || finish));

endmodule

// ==== verilog/band_sequencer.sv ====
`include "eq_defines.svh"

module band_sequencer
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sample_strobe,
  input  logic [`EQ_SAMPLE_W-1:0] left_result,
  input  logic [`EQ_SAMPLE_W-1:0] right_result,
  input  logic                    left_done,
  input  logic                    right_done,
  output eq_pkg::band_idx_t       band,
  output logic                    mac_start,
  output eq_pkg::stereo_t         audio_out,
  output logic                    out_valid,
  output logic                    busy
);

  localparam eq_pkg::band_idx_t LAST_BAND = eq_pkg::band_idx_t'(`EQ_BANDS - 1);

  typedef enum logic [1:0]
  {
    S_IDLE,
    S_RUN,
    S_SUM
  } state_t;

  state_t                  state;
  logic                    pair_done;
  logic [`EQ_SAMPLE_W-1:0] left_band  [`EQ_BANDS];
  logic [`EQ_SAMPLE_W-1:0] right_band [`EQ_BANDS];
  eq_pkg::stereo_t         band_sum;

  assign pair_done = left_done && right_done;

  always_comb
  begin
    band_sum = '0;
    for (int b = 0; b < `EQ_BANDS; b++)
    begin
      band_sum.left  = band_sum.left + left_band[b];
      band_sum.right = band_sum.right + right_band[b];
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Sweep FSM
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= S_IDLE;
      band      <= '0;
      mac_start <= 1'b0;
      out_valid <= 1'b0;
      busy      <= 1'b0;
      audio_out <= '0;
    end
    else
    begin
      mac_start <= 1'b0;
      out_valid <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (sample_strobe)  // Strobes while busy only shift the window
          begin
            state     <= S_RUN;
            band      <= '0;
            mac_start <= 1'b1;
            busy      <= 1'b1;
          end
        end
        S_RUN:
        begin
          if (pair_done)
          begin
            if (band == LAST_BAND)
              state <= S_SUM;
            else
            begin
              band      <= band + 1'b1;
              mac_start <= 1'b1;
            end
          end
        end
        S_SUM:
        begin
          audio_out <= band_sum;
          out_valid <= 1'b1;
          busy      <= 1'b0;
          state     <= S_IDLE;
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Per-band results
  always_ff @(posedge clk)
  begin
    if (state == S_RUN && pair_done)
    begin
      left_band[band]  <= left_result;
      right_band[band] <= right_result;
    end
  end

  // Both channel scalers run in lockstep
  a_done_pair: assert property (@(posedge clk) disable iff (reset)
    left_done == right_done);

  a_band_range: assert property (@(posedge clk) disable iff (reset)
    band <= LAST_BAND);

endmodule

// ==== verilog/eq_top.sv ====
`include "eq_defines.svh"

module eq_top
(
  input  logic                clk,
  input  logic                reset,
  input  logic                sample_strobe,
  input  eq_pkg::stereo_t     sample_in,
  input  eq_pkg::band_gains_t gains,
  output eq_pkg::stereo_t     audio_out,
  output logic                out_valid,
  output logic                busy
);

  logic [`EQ_SAMPLE_W-1:0] left_taps  [`EQ_TAPS];
  logic [`EQ_SAMPLE_W-1:0] right_taps [`EQ_TAPS];
  eq_pkg::band_idx_t       band;
  logic                    mac_start;
  eq_pkg::band_coefs_t     band_coefs;
  logic [`EQ_GAIN_W-1:0]   band_gain;
  logic [`EQ_SAMPLE_W-1:0] left_acc;
  logic [`EQ_SAMPLE_W-1:0] right_acc;
  logic                    left_acc_valid;
  logic                    right_acc_valid;
  logic [`EQ_SAMPLE_W-1:0] left_result;
  logic [`EQ_SAMPLE_W-1:0] right_result;
  logic                    left_done;
  logic                    right_done;

  // Current band drives both channels
  assign band_coefs = eq_pkg::coef_table[band];
  assign band_gain  = gains[band];

  sample_window sample_window_inst
  (
    .clk           (clk),
    .reset         (reset),
    .sample_strobe (sample_strobe),
    .sample_in     (sample_in),
    .left_taps     (left_taps),
    .right_taps    (right_taps)
  );

  band_sequencer band_sequencer_inst
  (
    .clk           (clk),
    .reset         (reset),
    .sample_strobe (sample_strobe),
    .left_result   (left_result),
    .right_result  (right_result),
    .left_done     (left_done),
    .right_done    (right_done),
    .band          (band),
    .mac_start     (mac_start),
    .audio_out     (audio_out),
    .out_valid     (out_valid),
    .busy          (busy)
  );

  fir_pair_mac left_mac_inst
  (
    .clk       (clk),
    .reset     (reset),
    .taps      (left_taps),
    .coefs     (band_coefs),
    .mac_start (mac_start),
    .acc       (left_acc),
    .acc_valid (left_acc_valid)
  );

  fir_pair_mac right_mac_inst
  (
    .clk       (clk),
    .reset     (reset),
    .taps      (right_taps),
    .coefs     (band_coefs),
    .mac_start (mac_start),
    .acc       (right_acc),
    .acc_valid (right_acc_valid)
  );

  band_scaler left_scaler_inst
  (
    .clk       (clk),
    .reset     (reset),
    .acc       (left_acc),
    .acc_valid (left_acc_valid),
    .gain      (band_gain),
    .result    (left_result),
    .done      (left_done)
  );

  band_scaler right_scaler_inst
  (
    .clk       (clk),
    .reset     (reset),
    .acc       (right_acc),
    .acc_valid (right_acc_valid),
    .gain      (band_gain),
    .result    (right_result),
    .done      (right_done)
  );

endmodule

// ==== verif/eq_tb.sv ====
`include "eq_defines.svh"

module eq_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 400;

  typedef struct packed
  {
    eq_pkg::stereo_t     sample;
    eq_pkg::band_gains_t gains;
    logic                wait_sweep;  // Wait for out_valid after this strobe
    logic                check;
    eq_pkg::stereo_t     expected;
    logic [2:0]          test;
  } row_t;

  logic                clk;
  logic                reset;
  logic                sample_strobe;
  eq_pkg::stereo_t     sample_in;
  eq_pkg::band_gains_t gains;
  eq_pkg::stereo_t     audio_out;
  logic                out_valid;
  logic                busy;

  row_t                    rows [$];
  logic [`EQ_SAMPLE_W-1:0] left_win  [`EQ_TAPS];  // Model window, tap 0 newest
  logic [`EQ_SAMPLE_W-1:0] right_win [`EQ_TAPS];
  logic [31:0]             rng;
  bit                      pending;
  int                      accepted;
  int                      valid_count;
  int                      errors;
  int                      checks;
  string                   test_names [6];

  eq_top eq_top_inst
  (
    .clk           (clk),
    .reset         (reset),
    .sample_strobe (sample_strobe),
    .sample_in     (sample_in),
    .gains         (gains),
    .audio_out     (audio_out),
    .out_valid     (out_valid),
    .busy          (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk)
  begin
    if (out_valid === 1'b1)
      valid_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [31:0] band_value(input bit right, input int b, input logic [3:0] g);
    eq_pkg::coef_t c;
    logic [31:0]   p;
    logic [31:0]   pmag;
    logic [31:0]   term;
    logic [31:0]   acc;
    logic [31:0]   q;
    logic [63:0]   wide;
    acc = '0;
    for (int k = 0; k < `EQ_PAIRS; k++)
    begin
      c = eq_pkg::coef_table[b][k];
      if (right)
        p = right_win[k] + right_win[`EQ_TAPS-1-k];
      else
        p = left_win[k] + left_win[`EQ_TAPS-1-k];
      pmag = p[31] ? 32'd0 - p : p;
      wide = 64'(c.mag) * 64'(pmag);
      term = (c.neg != p[31]) ? 32'd0 - wide[31:0] : wide[31:0];
      acc  = acc + term;
    end
    q    = (acc[31] ? 32'd0 - acc : acc) / 32'(`EQ_SCALE_DIV);
    wide = 64'(q) * 64'(g);
    return acc[31] ? 32'd0 - wide[31:0] : wide[31:0];
  endfunction

  function automatic eq_pkg::stereo_t sweep_value(input eq_pkg::band_gains_t g);
    eq_pkg::stereo_t s;
    s = '0;
    for (int b = 0; b < `EQ_BANDS; b++)
    begin
      s.left  = s.left + band_value(1'b0, b, g[b]);
      s.right = s.right + band_value(1'b1, b, g[b]);
    end
    return s;
  endfunction

  // Shifts the model window and records what the DUT should report
  task automatic add_row(input eq_pkg::stereo_t s, input eq_pkg::band_gains_t g,
                         input bit wait_sweep, input logic [2:0] test);
    row_t r;
    bit   starts;
    for (int i = `EQ_TAPS - 1; i > 0; i--)
    begin
      left_win[i]  = left_win[i-1];
      right_win[i] = right_win[i-1];
    end
    left_win[0]  = s.left;
    right_win[0] = s.right;
    starts = !pending;  // Otherwise the DUT is mid-sweep
    if (starts)
    begin
      accepted++;
      pending = 1'b1;
    end
    if (wait_sweep)
      pending = 1'b0;
    r.sample     = s;
    r.gains      = g;
    r.wait_sweep = wait_sweep;
    r.check      = wait_sweep && starts;
    r.expected   = sweep_value(g);
    r.test       = test;
    rows.push_back(r);
  endtask

  task automatic build_table();
    eq_pkg::stereo_t     s;
    eq_pkg::band_gains_t g;
    logic [31:0]         r;
    logic [3:0]          levels [3];
    levels = '{4'd1, 4'd7, 4'd15};

    // Impulse walks through all 45 taps
    g       = {`EQ_BANDS{4'd1}};
    s.left  = 32'd4000000;
    s.right = 32'd0 - 32'd3000000;
    add_row(s, g, 1'b1, 3'd1);
    for (int i = 1; i < `EQ_TAPS; i++)
      add_row('0, g, 1'b1, 3'd1);

    // All gains zero, then one band at a time
    for (int i = 0; i < 5; i++)
    begin
      s.left  = next_rand() >> 8;
      s.right = next_rand() >> 8;
      add_row(s, '0, 1'b1, 3'd2);
    end
    for (int l = 0; l < 3; l++)
    begin
      for (int b = 0; b < `EQ_BANDS; b++)
      begin
        r       = next_rand();
        s.left  = {{4{r[31]}}, r[31:4]};
        r       = next_rand();
        s.right = {{4{r[31]}}, r[31:4]};
        g       = '0;
        g[b]    = levels[l];
        add_row(s, g, 1'b1, 3'd2);
      end
    end

    // Opposite signs on the two channels
    for (int b = 0; b < `EQ_BANDS; b++)
      g[b] = 4'(b + 3);
    for (int i = 0; i < 12; i++)
    begin
      s.left  = next_rand() >> 6;
      s.right = next_rand() >> 6;
      if (i % 2 == 0)
        s.left = 32'd0 - s.left;
      else
        s.right = 32'd0 - s.right;
      add_row(s, g, 1'b1, 3'd3);
    end

    for (int i = 0; i < 24; i++)
    begin
      s.left  = next_rand();
      s.right = next_rand();
      r       = next_rand();
      add_row(s, eq_pkg::band_gains_t'(r[27:0]), 1'b1, 3'd4);
    end

    // Two strobes land mid-sweep each round
    g = {`EQ_BANDS{4'd2}};
    for (int n = 0; n < 2; n++)
    begin
      for (int i = 0; i < 4; i++)
      begin
        s.left  = next_rand() >> 2;
        s.right = next_rand() >> 3;
        add_row(s, g, i >= 2, 3'd5);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////////////////////////

  task automatic strobe_sample(input row_t r);
    @(posedge clk);
    sample_strobe <= 1'b1;
    sample_in     <= r.sample;
    gains         <= r.gains;
    @(posedge clk);
    sample_strobe <= 1'b0;
  endtask

  // A sweep is running, so busy stays high until out_valid
  task automatic wait_out_valid(input int idx, output bit seen);
    int n;
    bit busy_low;
    seen     = 1'b0;
    busy_low = 1'b0;
    n        = 0;
    while (!seen && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      seen = out_valid;
      if (!seen && busy !== 1'b1 && !busy_low)
      begin
        $display("ERR row %0d busy expected %h got %h", idx, 1'b1, busy);
        errors++;
        busy_low = 1'b1;
      end
      n++;
    end
  endtask

  task automatic compare_sweep(input int idx, input eq_pkg::stereo_t exp);
    checks++;
    if (audio_out.left !== exp.left)
    begin
      $display("ERR row %0d audio_out.left expected %h got %h", idx, exp.left, audio_out.left);
      errors++;
    end
    if (audio_out.right !== exp.right)
    begin
      $display("ERR row %0d audio_out.right expected %h got %h", idx, exp.right,
               audio_out.right);
      errors++;
    end
    if (busy !== 1'b0)
    begin
      $display("ERR row %0d busy expected %h got %h", idx, 1'b0, busy);
      errors++;
    end
  endtask

  task automatic report_test(input int id, input int base);
    if (errors == base)
      $display("test %0d %s: ok", id, test_names[id]);
    else
      $display("test %0d %s: %0d errors", id, test_names[id], errors - base);
  endtask

  initial
  begin
    int base;
    bit seen;
    bit abort;
    reset         = 1'b1;
    sample_strobe = 1'b0;
    sample_in     = '0;
    gains         = '0;
    abort         = 1'b0;
    rng           = 32'h2cc4_4d47;
    test_names    = '{"reset state", "impulse response", "band isolation",
                      "sign handling", "random audio", "strobe while busy"};
    for (int i = 0; i < `EQ_TAPS; i++)
    begin
      left_win[i]  = '0;
      right_win[i] = '0;
    end
    build_table();

    repeat (16) @(posedge clk);
    reset <= 1'b0;

    base = errors;
    for (int i = 0; i < 20; i++)
    begin
      @(negedge clk);
      checks++;
      if (audio_out !== '0)
      begin
        $display("ERR audio_out expected %h got %h", 64'h0, audio_out);
        errors++;
      end
      if (out_valid !== 1'b0 || busy !== 1'b0)
      begin
        $display("ERR out_valid/busy expected %h got %h", 2'b00, {out_valid, busy});
        errors++;
      end
    end
    report_test(0, base);

    base = errors;
    for (int i = 0; i < rows.size() && !abort; i++)
    begin
      strobe_sample(rows[i]);
      if (rows[i].wait_sweep)
      begin
        wait_out_valid(i, seen);
        if (!seen)
        begin
          $display("timeout: no out_valid within %0d cycles after row %0d", WAIT_LIMIT, i);
          errors++;
          abort = 1'b1;
        end
        else if (rows[i].check)
          compare_sweep(i, rows[i].expected);
      end
      if (abort || i == rows.size() - 1 || rows[i+1].test != rows[i].test)
      begin
        report_test(rows[i].test, base);
        base = errors;
      end
    end

    // Watch one sweep length for a stray pulse
    seen = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !abort && !seen; n++)
    begin
      @(negedge clk);
      seen = out_valid;
    end
    checks++;
    if (seen || valid_count != accepted)
    begin
      $display("ERR out_valid count expected %h got %h", accepted, valid_count);
      errors++;
    end
    $display("pulse count %0d for %0d accepted strobes", valid_count, accepted);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/eq_pkg.sv
verilog/sample_window.sv
verilog/fir_pair_mac.sv
verilog/band_scaler.sv
verilog/band_sequencer.sv
verilog/eq_top.sv
verif/eq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the equalizer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module eq_tb -Mdir obj_dir -f sim.f

if ! ./obj_dir/Veq_tb > sim.log 2>&1
then
  cat sim.log
  exit 1
fi

cat sim.log

if grep -q "TESTBENCH FAILED" sim.log
then
  exit 1
fi
